// ==== design/bpu_params.svh ====
`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// ==================================================
// Branch prediction unit sizing
// ==================================================

// Width of a program counter or branch target
`define BPU_PC_WIDTH 32

// Counter table holds 2**BPU_PHT_BITS entries
`define BPU_PHT_BITS 10
`define BPU_PHT_SIZE (1 << `BPU_PHT_BITS)

// BTB holds 2**BPU_BTB_BITS direct-mapped entries
`define BPU_BTB_BITS 6
`define BPU_BTB_SIZE (1 << `BPU_BTB_BITS)

// Instructions are word aligned so PC bits 1:0 never index anything
`define BPU_PC_LSB 2

// The tag is whatever sits above the BTB index
`define BPU_BTB_TAG_WIDTH (`BPU_PC_WIDTH - `BPU_BTB_BITS - `BPU_PC_LSB)

// Predictions that may wait for resolution at the same time
`define BPU_QUEUE_DEPTH 4

`endif

// ==== design/bpu_pkg.sv ====
`include "bpu_params.svh"

package bpu_pkg;

    // Program counter or target address
    typedef logic [`BPU_PC_WIDTH-1:0] pc_t;

    // Hashed index into the direction counter table
    typedef logic [`BPU_PHT_BITS-1:0] pht_index_t;

    // Two bit saturating counter, the upper bit is the predicted direction
    typedef logic [1:0] sat_counter_t;

    // Set index and tag of the BTB, both sliced out of the PC
    typedef logic [`BPU_BTB_BITS-1:0] btb_index_t;
    typedef logic [`BPU_BTB_TAG_WIDTH-1:0] btb_tag_t;

    // Lookup request coming from fetch
    typedef struct packed {
        logic valid;
        pc_t  pc;
    } fetch_req_t;

    // Answer returned to fetch in the same cycle
    typedef struct packed {
        logic hit;
        logic taken;
        pc_t  target;
    } prediction_t;

    // Branch outcome coming back from execute
    typedef struct packed {
        logic valid;
        logic predicted;
        logic taken;
        pc_t  pc;
        pc_t  target;
    } resolve_t;

    // What the queue remembers about one in-flight prediction
    typedef struct packed {
        logic       taken;
        pht_index_t index;
    } pred_entry_t;

endpackage : bpu_pkg

// ==== design/branch_target_buffer.sv ====
`timescale 1ns/1ps

`include "bpu_params.svh"

module branch_target_buffer
    import bpu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Fetch side lookup
    input  pc_t      lookup_pc_i,
    output logic     hit_o,
    output pc_t      target_o,

    // Resolved branch from execute
    input  resolve_t resolve_i
);

    // ==================================================
    // Address slicing
    // ==================================================

    btb_index_t lookup_idx;
    btb_tag_t   lookup_tag;
    btb_index_t update_idx;
    btb_tag_t   update_tag;

    // Index sits just above the word offset and the tag takes the rest
    assign lookup_idx = lookup_pc_i[`BPU_BTB_BITS + `BPU_PC_LSB - 1:`BPU_PC_LSB];
    assign lookup_tag = lookup_pc_i[`BPU_PC_WIDTH - 1:`BPU_BTB_BITS + `BPU_PC_LSB];

    // Same slicing for the branch that is being resolved
    assign update_idx = resolve_i.pc[`BPU_BTB_BITS + `BPU_PC_LSB - 1:`BPU_PC_LSB];
    assign update_tag = resolve_i.pc[`BPU_PC_WIDTH - 1:`BPU_BTB_BITS + `BPU_PC_LSB];

    // ==================================================
    // Entry storage
    // ==================================================

    logic [`BPU_BTB_SIZE-1:0] valid_q;
    btb_tag_t                 tag_q    [`BPU_BTB_SIZE];
    pc_t                      target_q [`BPU_BTB_SIZE];
    logic                     alloc;

    // Only taken branches earn an entry
    // A not-taken branch would never redirect fetch so it is left out
    assign alloc = resolve_i.valid && resolve_i.taken;

    // Valid bits are the only state that must start known
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (alloc) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    // Tag and target simply overwrite whatever lived in the set before
    // This is also how an aliasing branch replaces an older one
    always_ff @(posedge clk_i) begin
        if (alloc) begin
            tag_q[update_idx]    <= update_tag;
            target_q[update_idx] <= resolve_i.target;
        end
    end

    // ==================================================
    // Lookup
    // ==================================================

    // Purely combinational so fetch sees the answer in the same cycle
    // A write in this cycle only becomes visible after the edge
    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

endmodule : branch_target_buffer

// ==== design/prediction_queue.sv ====
`timescale 1ns/1ps

`include "bpu_params.svh"

module prediction_queue
    import bpu_pkg::*;
#(
    parameter int DEPTH = `BPU_QUEUE_DEPTH
) (
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Write side, one new prediction per cycle
    input  logic        push_i,
    input  pred_entry_t push_data_i,

    // Read side, oldest prediction leaves on pop
    input  logic        pop_i,
    output pred_entry_t head_o,

    output logic        full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Pointers wrap on their own because DEPTH is a power of two
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;

    // One extra bit so a completely full queue can be told apart from empty
    logic [PTR_W:0]   count_q;

    pred_entry_t      mem_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Push and pop together leave the occupancy unchanged
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Head is read straight from the array, no output register
    assign head_o = mem_q[rd_ptr_q];
    assign full_o = (count_q == (PTR_W + 1)'(DEPTH));

endmodule : prediction_queue

// ==== design/gshare_predictor.sv ====
`timescale 1ns/1ps

`include "bpu_params.svh"

module gshare_predictor
    import bpu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Fetch side, predict_i means the BTB hit and a slot is free
    input  logic     predict_i,
    input  pc_t      lookup_pc_i,
    output logic     taken_o,
    output logic     stall_o,

    // Execute side
    input  resolve_t resolve_i,
    output logic     mispredict_o
);

    // ==================================================
    // Global history
    // ==================================================

    pht_index_t ghr_q;

    // Updated only when a branch resolves, never speculatively
    // Older outcomes move up and the newest one lands in bit 0
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (resolve_i.valid) begin
            ghr_q <= {ghr_q[`BPU_PHT_BITS-2:0], resolve_i.taken};
        end
    end

    // ==================================================
    // Hash and prediction
    // ==================================================

    pht_index_t   predict_idx;
    sat_counter_t predict_ctr;

    // Word address bits of the PC folded with the history
    assign predict_idx = lookup_pc_i[`BPU_PHT_BITS + `BPU_PC_LSB - 1:`BPU_PC_LSB] ^ ghr_q;

    // Counter table, 2 read ports and 1 write port
    sat_counter_t pht_q [`BPU_PHT_SIZE];

    // Prediction port uses the fresh hash
    assign predict_ctr = pht_q[predict_idx];

    // Upper counter bit gives the direction (2 and 3 mean taken)
    assign taken_o = predict_ctr[1];

    // ==================================================
    // In-flight prediction queue
    // ==================================================

    pred_entry_t push_entry;
    pred_entry_t head_entry;
    logic        train;

    // The index is saved so training hits the same counter that predicted
    // even if the history has moved on since then
    assign push_entry.taken = taken_o;
    assign push_entry.index = predict_idx;

    // Only branches that got a prediction have an entry to retire
    assign train = resolve_i.valid && resolve_i.predicted;

    prediction_queue #(
        .DEPTH       (`BPU_QUEUE_DEPTH)
    ) u_queue (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (predict_i),
        .push_data_i (push_entry),
        .pop_i       (train),
        .head_o      (head_entry),
        .full_o      (stall_o)
    );

    // ==================================================
    // Misprediction check and training
    // ==================================================

    sat_counter_t train_ctr;
    sat_counter_t train_next;

    // Training port is indexed by the queue head
    assign train_ctr = pht_q[head_entry.index];

    // Step toward the resolved direction and hold at either end
    always_comb begin
        train_next = train_ctr;
        if (resolve_i.taken) begin
            if (train_ctr != 2'd3) begin
                train_next = train_ctr + 2'd1;
            end
        end else begin
            if (train_ctr != 2'd0) begin
                train_next = train_ctr - 2'd1;
            end
        end
    end

    // Compare against the direction that was handed to fetch back then
    // and not against the counter as it looks now
    assign mispredict_o = train && (head_entry.taken != resolve_i.taken);

    // All counters start strongly not taken
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BPU_PHT_SIZE; i++) begin
                pht_q[i] <= '0;
            end
        end else if (train) begin
            pht_q[head_entry.index] <= train_next;
        end
    end

endmodule : gshare_predictor

// ==== design/branch_predict_unit.sv ====
`timescale 1ns/1ps

module branch_predict_unit
    import bpu_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Fetch interface
    input  fetch_req_t  fetch_i,
    output prediction_t prediction_o,
    output logic        predict_stall_o,

    // Resolve interface from execute
    input  resolve_t    resolve_i,
    output logic        mispredict_o
);

    logic btb_hit;
    pc_t  btb_target;
    logic dir_taken;
    logic predict;

    // ==================================================
    // Target lookup
    // ==================================================

    branch_target_buffer u_btb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .lookup_pc_i (fetch_i.pc),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .resolve_i   (resolve_i)
    );

    // A prediction is only made when a queue slot is free
    // With the queue full fetch gets no hit and nothing is recorded
    assign predict = fetch_i.valid && btb_hit && !predict_stall_o;

    // ==================================================
    // Direction
    // ==================================================

    gshare_predictor u_gshare (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .predict_i    (predict),
        .lookup_pc_i  (fetch_i.pc),
        .taken_o      (dir_taken),
        .stall_o      (predict_stall_o),
        .resolve_i    (resolve_i),
        .mispredict_o (mispredict_o)
    );

    // Direction and target only mean something alongside hit
    // so both are held at zero otherwise
    assign prediction_o.hit    = predict;
    assign prediction_o.taken  = predict && dir_taken;
    assign prediction_o.target = predict ? btb_target : '0;

endmodule : branch_predict_unit

// ==== verification/bpu_ref_model.svh ====
`ifndef BPU_REF_MODEL_SVH
`define BPU_REF_MODEL_SVH

// ==================================================
// Reference model of the branch prediction unit
// ==================================================

// Mirror of the BTB, the counter table, the history and the queue
logic         m_btb_valid  [`BPU_BTB_SIZE];
btb_tag_t     m_btb_tag    [`BPU_BTB_SIZE];
pc_t          m_btb_target [`BPU_BTB_SIZE];
sat_counter_t m_pht        [`BPU_PHT_SIZE];
pht_index_t   m_ghr;
pred_entry_t  m_queue      [$];

// Word address modulo the set count picks the BTB set
function automatic btb_index_t btb_slot(input pc_t pc);
    return btb_index_t'(pc >> 2);
endfunction

function automatic btb_tag_t btb_tag_of(input pc_t pc);
    return btb_tag_t'(pc >> (`BPU_BTB_BITS + 2));
endfunction

// gshare hash, word address folded with the global history
function automatic pht_index_t hash_of(input pc_t pc);
    return pht_index_t'(pc >> 2) ^ m_ghr;
endfunction

function automatic void model_reset();
    m_btb_valid = '{default: 1'b0};
    m_pht       = '{default: 2'd0};
    m_ghr       = '0;
    m_queue.delete();
endfunction

// What fetch should see for this request with the current state
function automatic prediction_t predict_expect(input fetch_req_t f);
    prediction_t p;
    btb_index_t  s;
    s = btb_slot(f.pc);
    p = '0;
    p.hit = f.valid && m_btb_valid[s] && (m_btb_tag[s] == btb_tag_of(f.pc))
        && (m_queue.size() < `BPU_QUEUE_DEPTH);
    if (p.hit) begin
        p.taken  = (m_pht[hash_of(f.pc)] >= 2'd2);
        p.target = m_btb_target[s];
    end
    return p;
endfunction

// A miss is flagged only for predicted branches whose recorded direction was wrong
function automatic logic resolve_expect(input resolve_t r);
    if (r.valid && r.predicted && (m_queue.size() > 0)) begin
        return m_queue[0].taken != r.taken;
    end
    return 1'b0;
endfunction

function automatic logic stall_expect();
    return m_queue.size() == `BPU_QUEUE_DEPTH;
endfunction

// Moves the model across one clock edge with the inputs of the closing cycle
function automatic void model_step(input fetch_req_t f, input resolve_t r);
    prediction_t p;
    pred_entry_t e;
    pred_entry_t head;
    btb_index_t  s;
    // Everything the lookup needs is taken before any state changes
    p       = predict_expect(f);
    e.taken = p.taken;
    e.index = hash_of(f.pc);
    if (r.valid && r.predicted && (m_queue.size() > 0)) begin
        head = m_queue.pop_front();
        if (r.taken && (m_pht[head.index] != 2'd3)) begin
            m_pht[head.index] = m_pht[head.index] + 2'd1;
        end else if (!r.taken && (m_pht[head.index] != 2'd0)) begin
            m_pht[head.index] = m_pht[head.index] - 2'd1;
        end
    end
    if (p.hit) begin
        m_queue.push_back(e);
    end
    if (r.valid) begin
        m_ghr = (m_ghr << 1) | pht_index_t'(r.taken);
        if (r.taken) begin
            s               = btb_slot(r.pc);
            m_btb_valid[s]  = 1'b1;
            m_btb_tag[s]    = btb_tag_of(r.pc);
            m_btb_target[s] = r.target;
        end
    end
endfunction

`endif

// ==== verification/bpu_tb.sv ====
`timescale 1ns/1ps

`include "bpu_params.svh"

module bpu_tb
    import bpu_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int DIRECTED_MAX  = 200;
    localparam int RANDOM_CYCLES = 2000;
    localparam int MARGIN_CYCLES = 200;

    logic        clk_i;
    logic        rst_n_i;
    fetch_req_t  fetch;
    prediction_t prediction;
    logic        predict_stall;
    resolve_t    resolve;
    logic        mispredict;

    `include "bpu_ref_model.svh"

    // Fetched branches waiting for execute, oldest first
    typedef struct packed {
        pc_t  pc;
        logic predicted;
    } pending_t;

    pending_t pending [$];
    pc_t      pc_pool [8];
    int       pred_errors;
    int       mis_errors;
    int       stall_errors;
    logic     checking;

    branch_predict_unit uut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .fetch_i         (fetch),
        .prediction_o    (prediction),
        .predict_stall_o (predict_stall),
        .resolve_i       (resolve),
        .mispredict_o    (mispredict)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ==================================================
    // Compare tasks
    // ==================================================

    // Direction and target are only compared when a hit is expected
    task automatic check_prediction(input prediction_t got, input prediction_t exp);
        if ((got.hit !== exp.hit) || (exp.hit && ((got.taken !== exp.taken)
                || (got.target !== exp.target)))) begin
            pred_errors++;
            $display("Fail at %0t: prediction hit=%0b taken=%0b target=%h, expected %0b %0b %h",
                $time, got.hit, got.taken, got.target, exp.hit, exp.taken, exp.target);
        end
    endtask

    task automatic check_mispredict(input logic got, input logic exp);
        if (got !== exp) begin
            mis_errors++;
            $display("Fail at %0t: mispredict=%0b, expected %0b", $time, got, exp);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            stall_errors++;
            $display("Fail at %0t: predict_stall=%0b, expected %0b", $time, got, exp);
        end
    endtask

    // Outputs are sampled 1 ns before the edge and the model then steps over it
    always begin
        @(posedge clk_i);
        #(CLK_PERIOD - 1);
        if (checking) begin
            check_prediction(prediction, predict_expect(fetch));
            check_mispredict(mispredict, resolve_expect(resolve));
            check_stall(predict_stall, stall_expect());
            model_step(fetch, resolve);
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    function automatic logic coin(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    // Each branch always jumps to the same place
    function automatic pc_t target_of(input pc_t pc);
        return pc + 32'h0000_0200;
    endfunction

    // One cycle of inputs, a resolution always retires the oldest fetched branch
    task automatic step(input logic fetch_valid, input pc_t pc, input logic do_resolve,
                        input logic taken);
        fetch_req_t  f;
        resolve_t    r;
        pending_t    head;
        prediction_t p;
        @(posedge clk_i);
        #1;
        r = '0;
        if (do_resolve && (pending.size() > 0)) begin
            head        = pending.pop_front();
            r.valid     = 1'b1;
            r.predicted = head.predicted;
            r.taken     = taken;
            r.pc        = head.pc;
            r.target    = target_of(head.pc);
        end
        f.valid = fetch_valid;
        f.pc    = pc;
        p       = predict_expect(f);
        if (fetch_valid) begin
            pending.push_back('{pc: pc, predicted: p.hit});
        end
        fetch   = f;
        resolve = r;
    endtask

    task automatic drain();
        while (pending.size() > 0) begin
            step(1'b0, '0, 1'b1, coin(50));
        end
    endtask

    // Runs out of time only if the stimulus stops making progress
    initial begin
        #((RESET_CYCLES + DIRECTED_MAX + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the expected number of cycles");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [2:0] k;
        void'($urandom(32'h21e4ec36));
        // Sets 0 and 16 are each shared by PCs with different tags
        pc_pool = '{32'h0000_1000, 32'h0000_1100, 32'h0000_2000, 32'h0000_1040,
                    32'h0000_1044, 32'h0000_3040, 32'h0000_1140, 32'h0000_1048};
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        fetch        = '0;
        resolve      = '0;
        checking     = 1'b0;
        pred_errors  = 0;
        mis_errors   = 0;
        stall_errors = 0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i  = 1'b1;
        checking = 1'b1;

        // Allocation on taken only, then lookups that hit
        step(1'b0, '0, 1'b0, 1'b0);
        step(1'b1, pc_pool[0], 1'b0, 1'b0);
        step(1'b0, '0, 1'b1, 1'b1);
        step(1'b1, pc_pool[0], 1'b0, 1'b0);
        step(1'b1, pc_pool[3], 1'b1, 1'b1);
        step(1'b0, '0, 1'b1, 1'b0);
        step(1'b1, pc_pool[3], 1'b0, 1'b0);
        drain();

        // Counter training toward taken and back, with saturation at both ends
        // The first ten resolutions fill the history with ones, after that every
        // fetch of the branch lands on the same counter and walks it up to 3
        repeat (16) begin
            step(1'b1, pc_pool[0], 1'b0, 1'b0);
            step(1'b0, '0, 1'b1, 1'b1);
        end
        repeat (12) begin
            step(1'b1, pc_pool[0], 1'b0, 1'b0);
            step(1'b0, '0, 1'b1, 1'b0);
        end

        // Fill the queue, then push and pop in the same cycle
        repeat (5) step(1'b1, pc_pool[0], 1'b0, 1'b0);
        step(1'b0, '0, 1'b1, 1'b1);
        step(1'b1, pc_pool[0], 1'b1, 1'b1);
        step(1'b1, pc_pool[0], 1'b0, 1'b0);
        step(1'b1, pc_pool[0], 1'b0, 1'b0);
        drain();

        // Random mix with aliasing PCs
        repeat (RANDOM_CYCLES) begin
            k = 3'($urandom);
            step(coin(70) && (pending.size() < 8), pc_pool[k], coin(50), coin(65));
        end
        drain();
        step(1'b0, '0, 1'b0, 1'b0);
        #(CLK_PERIOD);
        checking = 1'b0;

        $display("Errors: prediction %0d, mispredict %0d, stall %0d",
            pred_errors, mis_errors, stall_errors);
        if ((pred_errors + mis_errors + stall_errors) == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : bpu_tb

// ==== compile.f ====
+incdir+design
+incdir+verification
design/bpu_pkg.sv
design/branch_target_buffer.sv
design/prediction_queue.sv
design/gshare_predictor.sv
design/branch_predict_unit.sv
verification/bpu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= bpu_tb
RTL_TOP    ?= branch_predict_unit
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only if the pass message shows up on a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
